// File: qspi_pkg.sv
package qspi_pkg;

    // Register port address width and byte offsets
    localparam int REG_ADDR_W = 6;

    localparam logic [REG_ADDR_W-1:0] ADDR_CCR = 6'h00;
    localparam logic [REG_ADDR_W-1:0] ADDR_ADR = 6'h04;
    localparam logic [REG_ADDR_W-1:0] ADDR_DR0 = 6'h08;
    localparam logic [REG_ADDR_W-1:0] ADDR_STA = 6'h28;

    // Data buffer geometry
    localparam int DR_WORDS  = 8;
    localparam int DR_BYTES  = DR_WORDS * 4;
    localparam int BUF_IDX_W = 5;

    // CCR field positions
    localparam int CCR_CMD_LSB     = 0;
    localparam int CCR_LANES_LSB   = 8;
    localparam int CCR_DIR_BIT     = 10;
    localparam int CCR_DUMMY_LSB   = 11;
    localparam int CCR_NBYTES_LSB  = 16;
    localparam int CCR_ADDR_EN_BIT = 21;
    localparam int CCR_DIV_LSB     = 24;
    localparam int CCR_START_BIT   = 31;

    localparam int DIV_W   = 6;
    localparam int DUMMY_W = 5;

    // Lane modes of the data phase where NONE sends the command only
    localparam logic [1:0] LANES_NONE = 2'd0;
    localparam logic [1:0] LANES_X1   = 2'd1;
    localparam logic [1:0] LANES_X2   = 2'd2;
    localparam logic [1:0] LANES_X4   = 2'd3;

    // STA bits
    localparam int STA_BUSY_BIT = 0;
    localparam int STA_DONE_BIT = 1;

endpackage

// File: qspi_regs.sv
module qspi_regs (
    input  logic                             clk_i,
    input  logic                             rst_ni,
    input  logic                             write_i,
    input  logic [3:0]                       data_be_i,
    input  logic [qspi_pkg::REG_ADDR_W-1:0]  addr_i,
    input  logic [31:0]                      wdata_i,
    input  logic [qspi_pkg::BUF_IDX_W-1:0]   tx_idx_i,
    input  logic                             rx_we_i,
    input  logic [qspi_pkg::BUF_IDX_W-1:0]   rx_idx_i,
    input  logic [7:0]                       rx_byte_i,
    input  logic                             done_i,
    output logic [31:0]                      rdata_o,
    output logic                             start_o,
    output logic [7:0]                       cmd_o,
    output logic [23:0]                      addr_o,
    output logic [1:0]                       lanes_o,
    output logic                             dir_o,
    output logic [qspi_pkg::DUMMY_W-1:0]     dummy_o,
    output logic [qspi_pkg::BUF_IDX_W-1:0]   nbytes_o,
    output logic                             addr_en_o,
    output logic [qspi_pkg::DIV_W-1:0]       div_o,
    output logic [7:0]                       tx_byte_o
);
    import qspi_pkg::*;

    logic [30:0]           ccr_q;
    logic [23:0]           adr_q;
    logic [7:0]            dr_q [DR_WORDS*4];
    logic                  busy_q;
    logic                  done_q;
    logic                  start_q;
    logic                  wr_ccr;
    logic                  wr_adr;
    logic                  wr_dr;
    logic                  in_dr;
    logic                  start_wr;
    logic [REG_ADDR_W-1:0] dr_off;
    logic [BUF_IDX_W-1:0]  dr_base;
    logic [31:0]           dr_word;
    logic [31:0]           rword;

    // Host writes are dropped while a transaction runs
    assign dr_off   = addr_i - ADDR_DR0;
    assign dr_base  = dr_off[BUF_IDX_W-1:0];
    assign in_dr    = (addr_i >= ADDR_DR0) && (dr_off < REG_ADDR_W'(DR_BYTES));
    assign wr_ccr   = write_i && !busy_q && (addr_i == ADDR_CCR);
    assign wr_adr   = write_i && !busy_q && (addr_i == ADDR_ADR);
    assign wr_dr    = write_i && !busy_q && in_dr;
    assign start_wr = wr_ccr && data_be_i[3] && wdata_i[CCR_START_BIT];

    //////////////////////////////////////////////////
    // Configuration and status
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ccr_q <= '0;
            adr_q <= '0;
        end else begin
            for (int k = 0; k < 3; k++) begin
                if (wr_ccr && data_be_i[k]) begin
                    ccr_q[8*k +: 8] <= wdata_i[8*k +: 8];
                end
                if (wr_adr && data_be_i[k]) begin
                    adr_q[8*k +: 8] <= wdata_i[8*k +: 8];
                end
            end
            // The top byte of CCR keeps everything below the start bit
            if (wr_ccr && data_be_i[3]) begin
                ccr_q[30:24] <= wdata_i[30:24];
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            busy_q  <= 1'b0;
            done_q  <= 1'b0;
            start_q <= 1'b0;
        end else begin
            start_q <= start_wr;
            if (start_wr) begin
                busy_q <= 1'b1;
                done_q <= 1'b0;
            end else if (done_i) begin
                busy_q <= 1'b0;
                done_q <= 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // Data buffer
    //////////////////////////////////////////////////

    // Host and engine never write in the same cycle, since the host is locked out while busy
    always_ff @(posedge clk_i) begin
        for (int k = 0; k < 4; k++) begin
            if (wr_dr && data_be_i[k]) begin
                dr_q[{dr_base[BUF_IDX_W-1:2], 2'(k)}] <= wdata_i[8*k +: 8];
            end
        end
        if (rx_we_i) begin
            dr_q[rx_idx_i] <= rx_byte_i;
        end
    end

    always_comb begin
        for (int k = 0; k < 4; k++) begin
            dr_word[8*k +: 8] = dr_q[{dr_base[BUF_IDX_W-1:2], 2'(k)}];
        end
    end

    //////////////////////////////////////////////////
    // Read mux
    //////////////////////////////////////////////////

    always_comb begin
        rword = '0;
        if (addr_i == ADDR_CCR) begin
            rword = {1'b0, ccr_q};
        end else if (addr_i == ADDR_ADR) begin
            rword = {8'h00, adr_q};
        end else if (addr_i == ADDR_STA) begin
            rword[STA_BUSY_BIT] = busy_q;
            rword[STA_DONE_BIT] = done_q;
        end else if (in_dr) begin
            rword = dr_word;
        end
        for (int k = 0; k < 4; k++) begin
            rdata_o[8*k +: 8] = data_be_i[k] ? rword[8*k +: 8] : 8'h00;
        end
    end

    assign start_o   = start_q;
    assign cmd_o     = ccr_q[CCR_CMD_LSB +: 8];
    assign lanes_o   = ccr_q[CCR_LANES_LSB +: 2];
    assign dir_o     = ccr_q[CCR_DIR_BIT];
    assign dummy_o   = ccr_q[CCR_DUMMY_LSB +: DUMMY_W];
    assign nbytes_o  = ccr_q[CCR_NBYTES_LSB +: BUF_IDX_W];
    assign addr_en_o = ccr_q[CCR_ADDR_EN_BIT];
    assign div_o     = ccr_q[CCR_DIV_LSB +: DIV_W];
    assign addr_o    = adr_q;
    assign tx_byte_o = dr_q[tx_idx_i];

endmodule

// File: qspi_sclk_gen.sv
module qspi_sclk_gen (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        run_i,
    input  logic [qspi_pkg::DIV_W-1:0]  div_i,
    output logic                        sclk_o,
    output logic                        rise_o,
    output logic                        fall_o
);
    import qspi_pkg::*;

    logic [DIV_W-1:0] cnt_q;
    logic             toggle;

    // SCLK flips once the counter has spent div_i plus one cycles in a half period
    assign toggle = run_i && (cnt_q == div_i);
    assign rise_o = toggle && !sclk_o;
    assign fall_o = toggle && sclk_o;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cnt_q  <= '0;
            sclk_o <= 1'b0;
        end else if (!run_i) begin
            // Mode 0 idle level
            cnt_q  <= '0;
            sclk_o <= 1'b0;
        end else if (toggle) begin
            cnt_q  <= '0;
            sclk_o <= !sclk_o;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

endmodule

// File: qspi_engine.sv
module qspi_engine (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    input  logic                            start_i,
    input  logic [7:0]                      cmd_i,
    input  logic [23:0]                     addr_i,
    input  logic [1:0]                      lanes_i,
    input  logic                            dir_i,
    input  logic [qspi_pkg::DUMMY_W-1:0]    dummy_i,
    input  logic [qspi_pkg::BUF_IDX_W-1:0]  nbytes_i,
    input  logic                            addr_en_i,
    input  logic                            rise_i,
    input  logic                            fall_i,
    input  logic [7:0]                      tx_byte_i,
    input  logic [3:0]                      io_i,
    output logic                            run_o,
    output logic                            cs_no,
    output logic [3:0]                      io_o,
    output logic [3:0]                      io_oe_o,
    output logic [qspi_pkg::BUF_IDX_W-1:0]  tx_idx_o,
    output logic                            rx_we_o,
    output logic [qspi_pkg::BUF_IDX_W-1:0]  rx_idx_o,
    output logic [7:0]                      rx_byte_o,
    output logic                            done_o
);
    import qspi_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_CMD,
        ST_ADDR,
        ST_DUMMY,
        ST_DATA
    } state_e;

    state_e                 state_q;
    state_e                 state_d;
    state_e                 tail_state;
    logic                   cs_nq;
    logic [BUF_IDX_W+2:0]   bit_q;
    logic [3:0]             lane_step;
    logic [3:0]             step;
    logic                   grp_last;
    logic                   phase_end;
    logic                   reading;
    logic [7:0]             rx_sh_q;
    logic [7:0]             rx_next;
    logic [7:0]             cmd_sh;
    logic [23:0]            adr_sh;
    logic [7:0]             tx_sh;

    // Bits moved per SCLK cycle in the data phase
    always_comb begin
        case (lanes_i)
            LANES_X2: lane_step = 4'd2;
            LANES_X4: lane_step = 4'd4;
            default:  lane_step = 4'd1;
        endcase
    end

    assign step     = (state_q == ST_DATA) ? lane_step : 4'd1;
    assign grp_last = ({1'b0, bit_q[2:0]} + lane_step) == 4'd8;
    assign reading  = (state_q == ST_DATA) && !dir_i;

    // Dummy clocks only lead into a data phase
    assign tail_state = (lanes_i == LANES_NONE) ? ST_IDLE :
                        (dummy_i != '0)         ? ST_DUMMY : ST_DATA;

    //////////////////////////////////////////////////
    // Phase sequencing
    //////////////////////////////////////////////////

    always_comb begin
        phase_end = 1'b0;
        state_d   = state_q;
        case (state_q)
            ST_CMD: begin
                phase_end = bit_q[2:0] == 3'd7;
                state_d   = addr_en_i ? ST_ADDR : tail_state;
            end
            ST_ADDR: begin
                phase_end = bit_q[4:0] == 5'd23;
                state_d   = tail_state;
            end
            ST_DUMMY: begin
                phase_end = bit_q[DUMMY_W-1:0] == dummy_i - 1'b1;
                state_d   = ST_DATA;
            end
            ST_DATA: begin
                phase_end = (bit_q[BUF_IDX_W+2:3] == nbytes_i) && grp_last;
                state_d   = ST_IDLE;
            end
            default: begin
                phase_end = 1'b0;
                state_d   = ST_IDLE;
            end
        endcase
    end

    // Phases change on the SCLK fall, so each bit is held for a full SCLK cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= ST_IDLE;
            cs_nq   <= 1'b1;
            bit_q   <= '0;
        end else if (state_q == ST_IDLE) begin
            if (start_i) begin
                state_q <= ST_CMD;
                cs_nq   <= 1'b0;
                bit_q   <= '0;
            end
        end else if (fall_i) begin
            if (phase_end) begin
                state_q <= state_d;
                cs_nq   <= state_d == ST_IDLE;
                bit_q   <= '0;
            end else begin
                bit_q <= bit_q + (BUF_IDX_W+3)'(step);
            end
        end
    end

    assign run_o  = state_q != ST_IDLE;
    assign cs_no  = cs_nq;
    assign done_o = fall_i && phase_end && (state_d == ST_IDLE);

    //////////////////////////////////////////////////
    // Serial data
    //////////////////////////////////////////////////

    always_comb begin
        cmd_sh  = cmd_i << bit_q[2:0];
        adr_sh  = addr_i << bit_q[4:0];
        tx_sh   = tx_byte_i << bit_q[2:0];
        io_o    = 4'b0000;
        io_oe_o = 4'b0000;
        case (state_q)
            ST_CMD: begin
                io_o[0] = cmd_sh[7];
                io_oe_o = 4'b0001;
            end
            ST_ADDR: begin
                io_o[0] = adr_sh[23];
                io_oe_o = 4'b0001;
            end
            ST_DATA: begin
                // Lane 0 takes the lowest bit of each group
                if (dir_i) begin
                    case (lanes_i)
                        LANES_X2: begin
                            io_o[1:0] = tx_sh[7:6];
                            io_oe_o   = 4'b0011;
                        end
                        LANES_X4: begin
                            io_o    = tx_sh[7:4];
                            io_oe_o = 4'b1111;
                        end
                        default: begin
                            io_o[0] = tx_sh[7];
                            io_oe_o = 4'b0001;
                        end
                    endcase
                end
            end
            default: begin
                io_oe_o = 4'b0000;
            end
        endcase
    end

    always_comb begin
        case (lanes_i)
            LANES_X2: rx_next = {rx_sh_q[5:0], io_i[1:0]};
            LANES_X4: rx_next = {rx_sh_q[3:0], io_i};
            default:  rx_next = {rx_sh_q[6:0], io_i[0]};
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reading && rise_i) begin
            rx_sh_q <= rx_next;
        end
    end

    // A read byte is complete on the rise that samples its last group
    assign rx_we_o   = reading && rise_i && grp_last;
    assign rx_byte_o = rx_next;
    assign rx_idx_o  = bit_q[BUF_IDX_W+2:3];
    assign tx_idx_o  = bit_q[BUF_IDX_W+2:3];

endmodule

// File: qspi_master.sv
module qspi_master (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    input  logic                            write_i,
    input  logic [3:0]                      data_be_i,
    input  logic [qspi_pkg::REG_ADDR_W-1:0] addr_i,
    input  logic [31:0]                     wdata_i,
    input  logic [3:0]                      io_i,
    output logic [31:0]                     rdata_o,
    output logic                            sclk_o,
    output logic                            cs_no,
    output logic [3:0]                      io_o,
    output logic [3:0]                      io_oe_o
);
    import qspi_pkg::*;

    logic                 start;
    logic                 done;
    logic [7:0]           cmd;
    logic [23:0]          addr;
    logic [1:0]           lanes;
    logic                 dir;
    logic [DUMMY_W-1:0]   dummy;
    logic [BUF_IDX_W-1:0] nbytes;
    logic                 addr_en;
    logic [DIV_W-1:0]     div;
    logic [BUF_IDX_W-1:0] tx_idx;
    logic [7:0]           tx_byte;
    logic                 rx_we;
    logic [BUF_IDX_W-1:0] rx_idx;
    logic [7:0]           rx_byte;
    logic                 run;
    logic                 rise;
    logic                 fall;

    qspi_regs regs_i (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .write_i   (write_i),
        .data_be_i (data_be_i),
        .addr_i    (addr_i),
        .wdata_i   (wdata_i),
        .tx_idx_i  (tx_idx),
        .rx_we_i   (rx_we),
        .rx_idx_i  (rx_idx),
        .rx_byte_i (rx_byte),
        .done_i    (done),
        .rdata_o   (rdata_o),
        .start_o   (start),
        .cmd_o     (cmd),
        .addr_o    (addr),
        .lanes_o   (lanes),
        .dir_o     (dir),
        .dummy_o   (dummy),
        .nbytes_o  (nbytes),
        .addr_en_o (addr_en),
        .div_o     (div),
        .tx_byte_o (tx_byte)
    );

    qspi_sclk_gen sclk_gen_i (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .run_i  (run),
        .div_i  (div),
        .sclk_o (sclk_o),
        .rise_o (rise),
        .fall_o (fall)
    );

    qspi_engine engine_i (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .start_i   (start),
        .cmd_i     (cmd),
        .addr_i    (addr),
        .lanes_i   (lanes),
        .dir_i     (dir),
        .dummy_i   (dummy),
        .nbytes_i  (nbytes),
        .addr_en_i (addr_en),
        .rise_i    (rise),
        .fall_i    (fall),
        .tx_byte_i (tx_byte),
        .io_i      (io_i),
        .run_o     (run),
        .cs_no     (cs_no),
        .io_o      (io_o),
        .io_oe_o   (io_oe_o),
        .tx_idx_o  (tx_idx),
        .rx_we_o   (rx_we),
        .rx_idx_o  (rx_idx),
        .rx_byte_o (rx_byte),
        .done_o    (done)
    );

endmodule

// File: qspi_flash_model.sv
module qspi_flash_model (
    input  logic                          sclk_i,
    input  logic                          cs_ni,
    input  logic [3:0]                    io_i,
    input  logic [1:0]                    lanes_i,
    input  logic                          dir_i,
    input  logic                          addr_en_i,
    input  logic [qspi_pkg::DUMMY_W-1:0]  dummy_i,
    output logic [3:0]                    io_o,
    output logic [3:0]                    io_oe_o
);
    timeunit 1ns;
    timeprecision 100ps;
    import qspi_pkg::*;

    logic [7:0]  cmd;
    logic [23:0] addr;
    logic [7:0]  wr_bytes [DR_BYTES];
    int          wr_count;
    int          clk_count;
    logic [7:0]  sh;
    logic [3:0]  drive;
    logic [3:0]  drive_oe;
    logic [3:0]  mask;
    int          width;
    int          hdr;

    always_comb begin
        case (lanes_i)
            LANES_X2: width = 2;
            LANES_X4: width = 4;
            default:  width = 1;
        endcase
        mask = 4'((1 << width) - 1);
        hdr  = 8 + (addr_en_i ? 24 : 0) + int'(dummy_i);
    end

    // A new transaction clears everything recorded by the previous one
    always @(negedge cs_ni) begin
        cmd       = 8'h00;
        addr      = 24'h0;
        wr_count  = 0;
        clk_count = 0;
        drive_oe  = 4'h0;
    end

    // The flash samples on the rising SCLK edge in mode 0
    always @(posedge sclk_i) begin
        if (!cs_ni) begin
            if (clk_count < 8) begin
                cmd = {cmd[6:0], io_i[0]};
            end else if (addr_en_i && clk_count < 32) begin
                addr = {addr[22:0], io_i[0]};
            end else if (dir_i && lanes_i != LANES_NONE && clk_count >= hdr) begin
                sh = (sh << width) | {4'h0, io_i & mask};
                if ((((clk_count - hdr + 1) * width) % 8) == 0 && wr_count < DR_BYTES) begin
                    wr_bytes[wr_count] = sh;
                    wr_count++;
                end
            end
            clk_count++;
        end
    end

    // Read data is the address low byte plus the byte index and is shifted out after the fall
    always @(negedge sclk_i) begin
        int         k;
        logic [7:0] v;
        if (!cs_ni && !dir_i && lanes_i != LANES_NONE && clk_count >= hdr) begin
            k        = clk_count - hdr;
            v        = addr[7:0] + 8'((k * width) / 8);
            v        = v << ((k * width) % 8);
            drive    = 4'(v >> (8 - width));
            drive_oe = mask;
        end else begin
            drive_oe = 4'h0;
        end
    end

    assign io_o    = drive;
    assign io_oe_o = cs_ni ? 4'h0 : drive_oe;

endmodule

// File: qspi_checker.sv
module qspi_checker (
    input  logic       clk_i,
    input  logic       rst_ni,
    input  logic       sclk_i,
    input  logic       cs_ni,
    input  logic [3:0] io_oe_i,
    input  logic [1:0] lanes_i,
    input  logic       dir_i,
    input  logic       busy_i,
    input  logic       done_i
);
    timeunit 1ns;
    timeprecision 100ps;
    import qspi_pkg::*;

    int unsigned fail_count = 0;

    // SCLK rests low whenever the flash is deselected
    a_idle_sclk: assert property (@(posedge clk_i) disable iff (!rst_ni) cs_ni |-> !sclk_i)
        else begin $error("SCLK is high while chip select is high"); fail_count++; end

    a_idle_oe: assert property (@(posedge clk_i) disable iff (!rst_ni) cs_ni |-> io_oe_i == 4'h0)
        else begin $error("Output enable is set while chip select is high"); fail_count++; end

    a_lane_x1: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (lanes_i == LANES_NONE || lanes_i == LANES_X1) |-> io_oe_i[3:1] == 3'b000)
        else begin $error("Upper lanes are driven in single-lane mode"); fail_count++; end

    a_lane_x2: assert property (@(posedge clk_i) disable iff (!rst_ni)
        lanes_i == LANES_X2 |-> io_oe_i[3:2] == 2'b00)
        else begin $error("Lanes 2 and 3 are driven in dual-lane mode"); fail_count++; end

    // Once a read releases the pins they stay released until deselect
    a_read_oe: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (!cs_ni && !dir_i && io_oe_i == 4'h0) |=> (io_oe_i == 4'h0 || cs_ni))
        else begin $error("Pins are driven again during the read phase"); fail_count++; end

    a_busy: assert property (@(posedge clk_i) disable iff (!rst_ni) !cs_ni |-> busy_i)
        else begin $error("Busy is low while chip select is low"); fail_count++; end

    a_end: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $rose(cs_ni) |-> (!busy_i && done_i))
        else begin $error("Busy and done did not update as chip select rose"); fail_count++; end

endmodule

bind qspi_master qspi_checker checker_i (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .sclk_i  (sclk_o),
    .cs_ni   (cs_no),
    .io_oe_i (io_oe_o),
    .lanes_i (lanes),
    .dir_i   (dir),
    .busy_i  (regs_i.busy_q),
    .done_i  (regs_i.done_q)
);

// File: tb_qspi_master.sv
module tb_qspi_master;
    timeunit 1ns;
    timeprecision 100ps;
    import qspi_pkg::*;

    logic                  clk;
    logic                  rst_n;
    logic                  write;
    logic [3:0]            be;
    logic [REG_ADDR_W-1:0] addr;
    logic [31:0]           wdata;
    logic [31:0]           rdata;
    logic                  sclk;
    logic                  cs_n;
    logic [3:0]            dut_io;
    logic [3:0]            dut_oe;
    logic [3:0]            fl_io;
    logic [3:0]            fl_oe;
    logic [3:0]            pins;
    logic [1:0]            fl_lanes;
    logic                  fl_dir;
    logic                  fl_addr_en;
    logic [DUMMY_W-1:0]    fl_dummy;
    int                    data_errors = 0;
    logic [7:0]            tx_bytes [8];

    // Each pin is driven by the master, else by the flash, else pulled up
    for (genvar i = 0; i < 4; i++) begin : g_pin
        assign pins[i] = dut_oe[i] ? dut_io[i] : (fl_oe[i] ? fl_io[i] : 1'b1);
    end

    qspi_master dut_i (
        .clk_i     (clk),
        .rst_ni    (rst_n),
        .write_i   (write),
        .data_be_i (be),
        .addr_i    (addr),
        .wdata_i   (wdata),
        .io_i      (pins),
        .rdata_o   (rdata),
        .sclk_o    (sclk),
        .cs_no     (cs_n),
        .io_o      (dut_io),
        .io_oe_o   (dut_oe)
    );

    qspi_flash_model flash_i (
        .sclk_i    (sclk),
        .cs_ni     (cs_n),
        .io_i      (pins),
        .lanes_i   (fl_lanes),
        .dir_i     (fl_dir),
        .addr_en_i (fl_addr_en),
        .dummy_i   (fl_dummy),
        .io_o      (fl_io),
        .io_oe_o   (fl_oe)
    );

    always #20 clk = !clk;

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
        assert (got === exp) else begin
            $display("CHECK FAILED at %0d ns: %s got %h expected %h", $time, what, got, exp);
            data_errors++;
        end
    endtask

    task automatic reg_write(input logic [REG_ADDR_W-1:0] a, input logic [31:0] d,
                             input logic [3:0] b);
        @(posedge clk);
        write <= 1'b1;
        addr  <= a;
        wdata <= d;
        be    <= b;
        @(posedge clk);
        write <= 1'b0;
    endtask

    task automatic reg_read(input logic [REG_ADDR_W-1:0] a, input logic [3:0] b,
                            output logic [31:0] d);
        @(posedge clk);
        addr <= a;
        be   <= b;
        @(negedge clk);
        d = rdata;
    endtask

    task automatic wait_idle();
        logic [31:0] sta;
        do begin
            reg_read(ADDR_STA, 4'hf, sta);
        end while (sta[STA_BUSY_BIT]);
    endtask

    task automatic start_xfer(input logic [7:0] cmd, input logic [1:0] lanes, input logic dir,
                              input int dummy, input int nbytes, input logic addr_en,
                              input int div, input logic wait_end);
        logic [31:0] ccr;
        fl_lanes   = lanes;
        fl_dir     = dir;
        fl_addr_en = addr_en;
        fl_dummy   = DUMMY_W'(dummy);
        ccr = {24'h0, cmd} | (32'(lanes) << CCR_LANES_LSB) | (32'(dir) << CCR_DIR_BIT)
            | (32'(dummy) << CCR_DUMMY_LSB) | (32'(nbytes - 1) << CCR_NBYTES_LSB)
            | (32'(addr_en) << CCR_ADDR_EN_BIT) | (32'(div) << CCR_DIV_LSB)
            | (32'h1 << CCR_START_BIT);
        reg_write(ADDR_CCR, ccr, 4'hf);
        if (wait_end) begin
            wait_idle();
        end
    endtask

    // Read bytes must follow the flash pattern of address low byte plus index
    task automatic check_read_pattern(input int n, input logic [7:0] lo);
        logic [31:0] w;
        for (int i = 0; i < n; i++) begin
            reg_read(ADDR_DR0 + REG_ADDR_W'(i & ~3), 4'hf, w);
            check_value({24'h0, w[8*(i%4) +: 8]}, {24'h0, lo + 8'(i)}, "read byte");
        end
    endtask

    initial begin
        #200us;
        $display("Watchdog timeout: the test sequence did not finish within 200 us");
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        logic [31:0] d1;
        logic [31:0] d2;
        logic [31:0] exp;
        logic [31:0] got;
        logic [3:0]  b;
        logic [23:0] adr;
        logic [REG_ADDR_W-1:0] a;
        void'($urandom(89));
        clk        = 1'b0;
        rst_n      = 1'b0;
        write      = 1'b0;
        be         = 4'h0;
        addr       = '0;
        wdata      = '0;
        fl_lanes   = LANES_NONE;
        fl_dir     = 1'b0;
        fl_addr_en = 1'b0;
        fl_dummy   = '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        // Reset state
        reg_read(ADDR_STA, 4'hf, got);
        check_value(got, 32'h0, "STA after reset");
        check_value({29'h0, cs_n, sclk, 1'b0}, {29'h0, 1'b1, 1'b0, 1'b0}, "cs_n and sclk idle");
        check_value({28'h0, dut_oe}, 32'h0, "io_oe idle");

        ////////////////////////////////////////////////
        // Register access
        ////////////////////////////////////////////////
        for (int i = 0; i < 9; i++) begin
            a  = (i == 0) ? ADDR_ADR : ADDR_DR0 + REG_ADDR_W'(4 * (i - 1));
            d1 = $urandom;
            d2 = $urandom;
            b  = 4'($urandom);
            reg_write(a, d1, 4'hf);
            reg_write(a, d2, b);
            for (int k = 0; k < 4; k++) begin
                exp[8*k +: 8] = b[k] ? d2[8*k +: 8] : d1[8*k +: 8];
            end
            if (i == 0) begin
                exp[31:24] = 8'h00;
            end
            reg_read(a, 4'hf, got);
            check_value(got, exp, "register readback");
            reg_read(a, b, got);
            for (int k = 0; k < 4; k++) begin
                if (!b[k]) begin
                    exp[8*k +: 8] = 8'h00;
                end
            end
            check_value(got, exp, "masked readback");
        end
        reg_write(ADDR_CCR, 32'h7f3f_ffff, 4'hf);
        reg_read(ADDR_CCR, 4'hf, got);
        check_value(got, 32'h7f3f_ffff, "CCR readback");

        ////////////////////////////////////////////////
        // Single-lane write of 8 bytes
        ////////////////////////////////////////////////
        for (int w = 0; w < 2; w++) begin
            d1 = $urandom;
            for (int k = 0; k < 4; k++) begin
                tx_bytes[4*w + k] = d1[8*k +: 8];
            end
            reg_write(ADDR_DR0 + REG_ADDR_W'(4 * w), d1, 4'hf);
        end
        adr = 24'($urandom);
        reg_write(ADDR_ADR, {8'h00, adr}, 4'hf);
        start_xfer(8'h02, LANES_X1, 1'b1, 0, 8, 1'b1, 1, 1'b1);
        check_value({24'h0, flash_i.cmd}, 32'h02, "write command");
        check_value({8'h0, flash_i.addr}, {8'h0, adr}, "write address");
        check_value(32'(flash_i.wr_count), 32'd8, "written byte count");
        for (int i = 0; i < 8; i++) begin
            check_value({24'h0, flash_i.wr_bytes[i]}, {24'h0, tx_bytes[i]}, "written byte");
        end
        reg_read(ADDR_STA, 4'hf, got);
        check_value(got, 32'h2, "STA after write");

        ////////////////////////////////////////////////
        // Dual-lane and quad-lane reads
        ////////////////////////////////////////////////
        adr = 24'($urandom);
        reg_write(ADDR_ADR, {8'h00, adr}, 4'hf);
        start_xfer(8'h3b, LANES_X2, 1'b0, 4, 12, 1'b1, 1, 1'b1);
        check_read_pattern(12, adr[7:0]);
        adr = 24'($urandom);
        reg_write(ADDR_ADR, {8'h00, adr}, 4'hf);
        start_xfer(8'h6b, LANES_X4, 1'b0, 6, 32, 1'b1, 0, 1'b1);
        check_read_pattern(32, adr[7:0]);

        ////////////////////////////////////////////////
        // Command only
        ////////////////////////////////////////////////
        start_xfer(8'h06, LANES_NONE, 1'b0, 0, 1, 1'b0, 2, 1'b1);
        check_value({24'h0, flash_i.cmd}, 32'h06, "lone command");
        check_value(32'(flash_i.clk_count), 32'd8, "SCLK cycles of lone command");
        reg_read(ADDR_CCR, 4'h8, got);
        check_value({31'h0, got[CCR_START_BIT]}, 32'h0, "CCR start bit");

        ////////////////////////////////////////////////
        // Busy protection
        ////////////////////////////////////////////////
        reg_write(ADDR_DR0 + REG_ADDR_W'(28), 32'ha5a5_5a5a, 4'hf);
        start_xfer(8'h03, LANES_X1, 1'b0, 2, 4, 1'b1, 3, 1'b0);
        reg_write(ADDR_DR0 + REG_ADDR_W'(28), 32'h1234_5678, 4'hf);
        wait_idle();
        reg_read(ADDR_DR0 + REG_ADDR_W'(28), 4'hf, got);
        check_value(got, 32'ha5a5_5a5a, "DR word written while busy");

        repeat (4) @(posedge clk);
        $display("Data errors: %0d, assertion errors: %0d",
                 data_errors, dut_i.checker_i.fail_count);
        if (data_errors == 0 && dut_i.checker_i.fail_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: project.f
qspi_pkg.sv
qspi_regs.sv
qspi_sclk_gen.sv
qspi_engine.sv
qspi_master.sv
qspi_flash_model.sv
qspi_checker.sv
tb_qspi_master.sv

// File: Makefile
TOP = tb_qspi_master

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f project.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f project.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee /dev/stderr | grep -q "^ALL CHECKS PASSED$$"

clean:
	rm -rf obj_dir
